/* Makefile */
VERILATOR ?= verilator
TOP ?= mp3_cpu_tb
OBJ_DIR ?= obj_dir
FILE_LIST ?= sources.f
VFLAGS ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"
	@echo "Variables: VERILATOR TOP OBJ_DIR FILE_LIST VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILE_LIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

/* control_memory.sv */
`timescale 1ns/1ps

module control_memory (
    input  rv32i_types::rv32i_word         instr,
    output rv32i_types::rv32i_control_word ctrl
);
    logic [2:0] funct3;
    logic alt;
    rv32i_types::rv32i_word i_imm;
    rv32i_types::rv32i_word s_imm;
    rv32i_types::rv32i_word b_imm;
    rv32i_types::rv32i_word u_imm;
    rv32i_types::rv32i_word j_imm;

    assign funct3 = instr[14:12];
    // Bit 30 selects SUB and SRA. Only SRAI honours it among immediate ops.
    assign alt = instr[30] & (instr[5] | (funct3 == 3'b101));

    assign i_imm = {{21{instr[31]}}, instr[30:20]};
    assign s_imm = {{21{instr[31]}}, instr[30:25], instr[11:7]};
    assign b_imm = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
    assign u_imm = {instr[31:12], 12'h000};
    assign j_imm = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

    always_comb begin
        ctrl = '0;
        ctrl.opcode = rv32i_types::rv32i_opcode'(instr[6:0]);
        ctrl.rs1 = instr[19:15];
        ctrl.rs2 = instr[24:20];
        ctrl.rd = instr[11:7];
        ctrl.aluop = rv32i_types::alu_add;
        ctrl.cmpop = rv32i_types::branch_funct3'(funct3);
        ctrl.alumux1 = rv32i_types::mux1_rs1;
        ctrl.alumux2 = rv32i_types::mux2_imm;
        ctrl.regfilemux = rv32i_types::rf_alu;
        ctrl.imm = i_imm;

        case (ctrl.opcode)
            rv32i_types::op_reg, rv32i_types::op_imm: begin
                ctrl.load_regfile = 1'b1;
                ctrl.aluop = rv32i_types::alu_ops'({alt, funct3});
                if (instr[5]) begin
                    ctrl.alumux2 = rv32i_types::mux2_rs2;
                end else begin
                    ctrl.rs2 = '0;
                end
                // Set-less-than results come from the comparator.
                if (funct3 == 3'b010) begin
                    ctrl.regfilemux = rv32i_types::rf_cmp;
                    ctrl.cmpop = rv32i_types::blt;
                end else if (funct3 == 3'b011) begin
                    ctrl.regfilemux = rv32i_types::rf_cmp;
                    ctrl.cmpop = rv32i_types::bltu;
                end
            end
            rv32i_types::op_lui, rv32i_types::op_auipc: begin
                ctrl.load_regfile = 1'b1;
                ctrl.rs1 = '0;
                ctrl.rs2 = '0;
                ctrl.imm = u_imm;
                if (instr[5] == 1'b0) begin
                    ctrl.alumux1 = rv32i_types::mux1_pc;
                end
            end
            rv32i_types::op_jal: begin
                ctrl.load_regfile = 1'b1;
                ctrl.is_jal = 1'b1;
                ctrl.rs1 = '0;
                ctrl.rs2 = '0;
                ctrl.imm = j_imm;
                ctrl.regfilemux = rv32i_types::rf_pc4;
            end
            rv32i_types::op_jalr: begin
                ctrl.load_regfile = 1'b1;
                ctrl.is_jalr = 1'b1;
                ctrl.rs2 = '0;
                ctrl.regfilemux = rv32i_types::rf_pc4;
            end
            rv32i_types::op_br: begin
                ctrl.is_branch = 1'b1;
                ctrl.alumux2 = rv32i_types::mux2_rs2;
                ctrl.imm = b_imm;
            end
            rv32i_types::op_load: begin
                ctrl.load_regfile = 1'b1;
                ctrl.mem_read = 1'b1;
                ctrl.rs2 = '0;
                ctrl.regfilemux = rv32i_types::rf_load;
            end
            rv32i_types::op_store: begin
                ctrl.mem_write = 1'b1;
                ctrl.imm = s_imm;
            end
            default: begin
                ctrl.rs1 = '0;
                ctrl.rs2 = '0;
            end
        endcase

        if (ctrl.rd == '0) begin
            ctrl.load_regfile = 1'b0;
        end
    end

endmodule

/* ex_stage.sv */
`timescale 1ns/1ps

module ex_stage (
    input  pipe_types::id_ex_t     id_ex,
    input  pipe_types::ex_mem_t    ex_mem,
    input  pipe_types::mem_wb_t    mem_wb,
    input  rv32i_types::rv32i_word mem_fwd_data,
    output pipe_types::ex_mem_t    ex_out,
    output logic                   redirect,
    output rv32i_types::rv32i_word target_pc
);
    pipe_types::fwd_sel fwd1;
    pipe_types::fwd_sel fwd2;
    rv32i_types::rv32i_word wb_fwd_data;
    rv32i_types::rv32i_word rs1_val;
    rv32i_types::rv32i_word rs2_val;
    rv32i_types::rv32i_word op_a;
    rv32i_types::rv32i_word op_b;
    rv32i_types::rv32i_word alu_out;
    logic cmp;

    // The memory stage holds the younger result, so it wins.
    function automatic pipe_types::fwd_sel fwd_pick(
        input rv32i_types::rv32i_reg rs,
        input pipe_types::ex_mem_t   m,
        input pipe_types::mem_wb_t   w
    );
        if (m.valid && m.ctrl.load_regfile && m.ctrl.rd == rs) begin
            return pipe_types::fwd_mem;
        end
        if (w.valid && w.ctrl.load_regfile && w.ctrl.rd == rs) begin
            return pipe_types::fwd_wb;
        end
        return pipe_types::fwd_none;
    endfunction

    function automatic rv32i_types::rv32i_word fwd_value(
        input pipe_types::fwd_sel     sel,
        input rv32i_types::rv32i_word reg_val,
        input rv32i_types::rv32i_word mem_val,
        input rv32i_types::rv32i_word wb_val
    );
        case (sel)
            pipe_types::fwd_mem: return mem_val;
            pipe_types::fwd_wb:  return wb_val;
            default:             return reg_val;
        endcase
    endfunction

    assign fwd1 = fwd_pick(id_ex.ctrl.rs1, ex_mem, mem_wb);
    assign fwd2 = fwd_pick(id_ex.ctrl.rs2, ex_mem, mem_wb);
    assign wb_fwd_data = pipe_types::wb_value(mem_wb);
    assign rs1_val = fwd_value(fwd1, id_ex.rs1_out, mem_fwd_data, wb_fwd_data);
    assign rs2_val = fwd_value(fwd2, id_ex.rs2_out, mem_fwd_data, wb_fwd_data);

    assign op_a = (id_ex.ctrl.alumux1 == rv32i_types::mux1_pc) ? id_ex.pc : rs1_val;
    assign op_b = (id_ex.ctrl.alumux2 == rv32i_types::mux2_imm) ? id_ex.ctrl.imm : rs2_val;

    always_comb begin
        case (id_ex.ctrl.aluop)
            rv32i_types::alu_sub:  alu_out = op_a - op_b;
            rv32i_types::alu_sll:  alu_out = op_a << op_b[4:0];
            rv32i_types::alu_slt:  alu_out = {31'b0, $signed(op_a) < $signed(op_b)};
            rv32i_types::alu_sltu: alu_out = {31'b0, op_a < op_b};
            rv32i_types::alu_xor:  alu_out = op_a ^ op_b;
            rv32i_types::alu_srl:  alu_out = op_a >> op_b[4:0];
            rv32i_types::alu_sra:  alu_out = $signed(op_a) >>> op_b[4:0];
            rv32i_types::alu_or:   alu_out = op_a | op_b;
            rv32i_types::alu_and:  alu_out = op_a & op_b;
            default:               alu_out = op_a + op_b;
        endcase
    end

    // Compares rs1 against rs2 for branches, against the immediate for SLTI.
    always_comb begin
        case (id_ex.ctrl.cmpop)
            rv32i_types::bne:  cmp = rs1_val != op_b;
            rv32i_types::blt:  cmp = $signed(rs1_val) < $signed(op_b);
            rv32i_types::bge:  cmp = $signed(rs1_val) >= $signed(op_b);
            rv32i_types::bltu: cmp = rs1_val < op_b;
            rv32i_types::bgeu: cmp = rs1_val >= op_b;
            default:           cmp = rs1_val == op_b;
        endcase
    end

    assign redirect = id_ex.valid &
        (id_ex.ctrl.is_jal | id_ex.ctrl.is_jalr | (id_ex.ctrl.is_branch & cmp));
    assign target_pc = id_ex.ctrl.is_jalr ? ((rs1_val + id_ex.ctrl.imm) & ~32'd1)
                                          : id_ex.pc + id_ex.ctrl.imm;

    assign ex_out = '{
        pc:      id_ex.pc,
        alu_out: alu_out,
        cmp_out: cmp,
        rs2_out: rs2_val,
        ctrl:    id_ex.ctrl,
        valid:   id_ex.valid
    };

endmodule

/* id_stage.sv */
`timescale 1ns/1ps

module id_stage (
    input  logic                   clk,
    input  logic                   arst_n,
    input  rv32i_types::rv32i_reg  rs1,
    input  rv32i_types::rv32i_reg  rs2,
    input  rv32i_types::rv32i_reg  wb_rd,
    input  logic                   wb_load,
    input  rv32i_types::rv32i_word wb_data,
    output rv32i_types::rv32i_word rs1_out,
    output rv32i_types::rv32i_word rs2_out
);
    rv32i_types::rv32i_word regs [31:1];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_load && wb_rd != '0) begin
            regs[wb_rd] <= wb_data;
        end
    end

    // The write of the current cycle is visible to the read.
    function automatic rv32i_types::rv32i_word read_reg(input rv32i_types::rv32i_reg idx);
        if (idx == '0) begin
            return '0;
        end
        if (wb_load && wb_rd == idx) begin
            return wb_data;
        end
        return regs[idx];
    endfunction

    always_comb begin
        rs1_out = read_reg(rs1);
        rs2_out = read_reg(rs2);
    end

endmodule

/* mp3_cpu.sv */
`timescale 1ns/1ps

module mp3_cpu #(
    parameter rv32i_types::rv32i_word RESET_PC = 32'h0000_0000
) (
    input  logic                   clk,
    input  logic                   arst_n,

    output logic                   read_a,
    output logic                   write_a,
    output logic [3:0]             wmask_a,
    output rv32i_types::rv32i_word address_a,
    output rv32i_types::rv32i_word wdata_a,
    input  logic                   resp_a,
    input  rv32i_types::rv32i_word rdata_a,

    output logic                   read_b,
    output logic                   write_b,
    output logic [3:0]             wmask_b,
    output rv32i_types::rv32i_word address_b,
    output rv32i_types::rv32i_word wdata_b,
    input  logic                   resp_b,
    input  rv32i_types::rv32i_word rdata_b
);
    rv32i_types::rv32i_word pc;
    rv32i_types::rv32i_word target_pc;
    rv32i_types::rv32i_word fetch_buf;
    rv32i_types::rv32i_word fetch_instr;
    rv32i_types::rv32i_word load_buf;
    rv32i_types::rv32i_word rs1_out;
    rv32i_types::rv32i_word rs2_out;
    rv32i_types::rv32i_word mem_fwd_data;
    rv32i_types::rv32i_word wb_data;
    rv32i_types::rv32i_control_word dec_ctrl;

    pipe_types::if_id_t  if_id;
    pipe_types::id_ex_t  id_ex;
    pipe_types::ex_mem_t ex_mem;
    pipe_types::ex_mem_t ex_out;
    pipe_types::mem_wb_t mem_wb;
    pipe_types::mem_wb_t mem_wb_in;

    logic fetch_done;
    logic mem_done;
    logic mem_busy;
    logic wb_load;
    logic load;
    logic load_use_stall;
    logic flush;
    logic redirect;

    // Instruction port. Read only.
    assign read_a = ~fetch_done;
    assign write_a = 1'b0;
    assign wmask_a = 4'b0000;
    assign wdata_a = '0;
    assign address_a = pc;
    assign fetch_instr = fetch_done ? fetch_buf : rdata_a;

    // Data port, driven from the memory-stage record.
    assign mem_busy = ex_mem.valid & (ex_mem.ctrl.mem_read | ex_mem.ctrl.mem_write) & ~mem_done;
    assign read_b = mem_busy & ex_mem.ctrl.mem_read;
    assign write_b = mem_busy & ex_mem.ctrl.mem_write;
    assign wmask_b = 4'b1111;
    assign address_b = ex_mem.alu_out;
    assign wdata_b = ex_mem.rs2_out;

    // Completed accesses wait here while the other port holds the pipeline.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            fetch_done <= 1'b0;
            mem_done <= 1'b0;
        end else begin
            if (load && !load_use_stall) begin
                fetch_done <= 1'b0;
            end else if (read_a && resp_a) begin
                fetch_done <= 1'b1;
            end
            if (load) begin
                mem_done <= 1'b0;
            end else if (mem_busy && resp_b) begin
                mem_done <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (read_a && resp_a) begin
            fetch_buf <= rdata_a;
        end
        if (read_b && resp_b) begin
            load_buf <= rdata_b;
        end
    end

    assign mem_wb_in = '{
        pc:      ex_mem.pc,
        alu_out: ex_mem.alu_out,
        cmp_out: ex_mem.cmp_out,
        rs2_out: ex_mem.rs2_out,
        rdata:   mem_done ? load_buf : rdata_b,
        ctrl:    ex_mem.ctrl,
        valid:   ex_mem.valid
    };
    assign mem_fwd_data = pipe_types::wb_value(mem_wb_in);

    assign wb_data = pipe_types::wb_value(mem_wb);
    assign wb_load = load & mem_wb.valid & mem_wb.ctrl.load_regfile;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc <= RESET_PC;
            if_id <= '0;
            id_ex <= '0;
            ex_mem <= '0;
            mem_wb <= '0;
        end else if (load) begin
            if (!load_use_stall) begin
                pc <= flush ? target_pc : pc + 32'd4;
                if_id.pc <= pc;
                if_id.instr <= fetch_instr;
                if_id.valid <= ~flush;
            end
            if (flush || load_use_stall) begin
                id_ex.valid <= 1'b0;
            end else begin
                id_ex <= '{
                    pc:      if_id.pc,
                    rs1_out: rs1_out,
                    rs2_out: rs2_out,
                    ctrl:    dec_ctrl,
                    valid:   if_id.valid
                };
            end
            ex_mem <= ex_out;
            mem_wb <= mem_wb_in;
        end
    end

    control_memory control_memory (
        .instr(if_id.instr),
        .ctrl(dec_ctrl)
    );

    id_stage id_stage (
        .clk,
        .arst_n,
        .rs1(dec_ctrl.rs1),
        .rs2(dec_ctrl.rs2),
        .wb_rd(mem_wb.ctrl.rd),
        .wb_load,
        .wb_data,
        .rs1_out,
        .rs2_out
    );

    ex_stage ex_stage (
        .id_ex,
        .ex_mem,
        .mem_wb,
        .mem_fwd_data,
        .ex_out,
        .redirect,
        .target_pc
    );

    pipe_control pipe_control (
        .read_a,
        .resp_a,
        .mem_busy,
        .resp_b,
        .ex_is_load(id_ex.valid & id_ex.ctrl.mem_read & id_ex.ctrl.load_regfile),
        .ex_rd(id_ex.ctrl.rd),
        .id_rs1(dec_ctrl.rs1),
        .id_rs2(dec_ctrl.rs2),
        .redirect,
        .load,
        .load_use_stall,
        .flush
    );

endmodule

/* mp3_cpu_asserts.sv */
`timescale 1ns/1ps

module mp3_cpu_asserts (
    input logic                   clk,
    input logic                   arst_n,
    input logic                   read_a,
    input logic                   resp_a,
    input rv32i_types::rv32i_word address_a,
    input logic                   read_b,
    input logic                   write_b,
    input logic                   resp_b,
    input rv32i_types::rv32i_word address_b,
    input rv32i_types::rv32i_word wdata_b,
    input logic                   load,
    input logic                   id_ex_valid
);
    // A pending request keeps its address and data until resp.
    fetch_held: assert property (@(posedge clk) disable iff (!arst_n)
        read_a && !resp_a |=> read_a && $stable(address_a))
        else $error("fetch request changed before resp_a");

    data_held: assert property (@(posedge clk) disable iff (!arst_n)
        (read_b || write_b) && !resp_b |=> $stable({read_b, write_b, address_b, wdata_b}))
        else $error("data request changed before resp_b");

    data_exclusive: assert property (@(posedge clk) disable iff (!arst_n)
        !(read_b && write_b))
        else $error("read_b and write_b high together");

    // A frozen pipeline neither redirects the fetch nor inserts a bubble.
    frozen_quiet: assert property (@(posedge clk) disable iff (!arst_n)
        !load |=> $stable(address_a) && $stable(id_ex_valid))
        else $error("fetch address or ID/EX valid changed while the pipeline is frozen");

endmodule

bind mp3_cpu mp3_cpu_asserts handshake_checks (
    .clk(clk),
    .arst_n(arst_n),
    .read_a(read_a),
    .resp_a(resp_a),
    .address_a(address_a),
    .read_b(read_b),
    .write_b(write_b),
    .resp_b(resp_b),
    .address_b(address_b),
    .wdata_b(wdata_b),
    .load(load),
    .id_ex_valid(id_ex.valid)
);

/* mp3_cpu_tb.sv */
`timescale 1ns/1ps

module mp3_cpu_tb;
    localparam int NUM_PROGS = 4;
    localparam int PROG_LEN = 40;
    localparam int LOOP_IDX = PROG_LEN + 31;
    localparam rv32i_types::rv32i_word LOOP_ADDR = LOOP_IDX * 4;
    localparam rv32i_types::rv32i_word LOOP_INSTR = 32'h0000_006f;
    localparam rv32i_types::rv32i_word NOP_INSTR = 32'h0000_0013;
    localparam int CYCLE_LIMIT = NUM_PROGS * 200 * 5;

    logic clk;
    logic clk_rst_n;
    logic prog_rst_n;
    logic arst_n;
    logic read_a, write_a, resp_a;
    logic read_b, write_b, resp_b;
    logic [3:0] wmask_a, wmask_b;
    rv32i_types::rv32i_word address_a, wdata_a, rdata_a;
    rv32i_types::rv32i_word address_b, wdata_b, rdata_b;

    rv32i_types::rv32i_word imem [0:255];
    rv32i_types::rv32i_word dmem [0:1023];
    rv32i_types::rv32i_word mdmem [0:1023];
    rv32i_types::rv32i_word mregs [0:31];
    rv32i_types::rv32i_word exp_addr [$];
    rv32i_types::rv32i_word exp_data [$];
    logic busy_a, busy_b, run_done;
    int wait_a, wait_b;
    int cycles;

    assign arst_n = clk_rst_n & prog_rst_n;

    tb_clock #(.PERIOD(10), .RESET_CYCLES(2)) clock_gen (.clk(clk), .arst_n(clk_rst_n));

    mp3_cpu #(.RESET_PC(32'h0000_0000)) UUT (.*);

    task automatic check_word(input string name, input rv32i_types::rv32i_word got,
                              input rv32i_types::rv32i_word expected);
        if (got !== expected) begin
            $display("mismatch at %0t: %s got %h expected %h", $time, name, got, expected);
            $display("Test failed");
            $fatal(1);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic expected);
        if (got !== expected) begin
            $display("mismatch at %0t: %s got %b expected %b", $time, name, got, expected);
            $display("Test failed");
            $fatal(1);
        end
    endtask

    function automatic rv32i_types::rv32i_word data_pattern(input int idx);
        return (idx * 32'h9e37_79b9) ^ 32'h1357_9bdf;
    endfunction

    function automatic rv32i_types::rv32i_word enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                                     input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic rv32i_types::rv32i_word enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                                     input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic rv32i_types::rv32i_word enc_j(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction

    // Forward-only control flow keeps every program finite.
    task automatic gen_program();
        logic [2:0] f3;
        logic [2:0] br_f3 [0:5];
        logic [4:0] rd, rs1, rs2;
        logic [11:0] imm;
        int k;
        br_f3 = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
        for (int i = 0; i < PROG_LEN; i++) begin
            rd = 5'(1 + $urandom % 15);
            rs1 = 5'($urandom % 16);
            rs2 = 5'($urandom % 16);
            f3 = 3'($urandom % 8);
            imm = 12'($urandom);
            k = 1 + $urandom % 3;
            if (i + k > PROG_LEN) begin
                k = PROG_LEN - i;
            end
            case ($urandom % 8)
                0, 1: imem[i] = {((f3 == 0 || f3 == 5) && $urandom % 2) ? 7'h20 : 7'h00,
                                 rs2, rs1, f3, rd, 7'b0110011};
                2: begin
                    if (f3 == 3'd1) begin
                        imm = {7'h00, imm[4:0]};
                    end else if (f3 == 3'd5) begin
                        imm = {($urandom % 2) ? 7'h20 : 7'h00, imm[4:0]};
                    end
                    imem[i] = {imm, rs1, f3, rd, 7'b0010011};
                end
                3: imem[i] = {20'($urandom), rd, ($urandom % 2) ? 7'b0110111 : 7'b0010111};
                4: imem[i] = {12'(12'h400 + 4 * ($urandom % 64)), 5'd0, 3'b010, rd, 7'b0000011};
                5: imem[i] = enc_s(12'(12'h400 + 4 * ($urandom % 64)), rs2, 5'd0);
                6: imem[i] = enc_b(13'(k * 4), rs2, rs1, br_f3[$urandom % 6]);
                default: imem[i] = enc_j(21'(k * 4), rd);
            endcase
        end
        // Register dump with one word per register.
        for (int r = 1; r < 32; r++) begin
            imem[PROG_LEN + r - 1] = enc_s(12'(12'h600 + 4 * r), 5'(r), 5'd0);
        end
        imem[LOOP_IDX] = LOOP_INSTR;
    endtask

    function automatic rv32i_types::rv32i_word alu_result(input logic [2:0] f3, input logic alt,
                                                          input rv32i_types::rv32i_word a,
                                                          input rv32i_types::rv32i_word b);
        case (f3)
            3'd0: return alt ? a - b : a + b;
            3'd1: return a << b[4:0];
            3'd2: return {31'b0, $signed(a) < $signed(b)};
            3'd3: return {31'b0, a < b};
            3'd4: return a ^ b;
            3'd5: return alt ? rv32i_types::rv32i_word'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic branch_taken(input logic [2:0] f3, input rv32i_types::rv32i_word a,
                                          input rv32i_types::rv32i_word b);
        case (f3)
            3'd0: return a == b;
            3'd1: return a != b;
            3'd4: return $signed(a) < $signed(b);
            3'd5: return $signed(a) >= $signed(b);
            3'd6: return a < b;
            default: return a >= b;
        endcase
    endfunction

    // Sequential instruction-set model. Records every store in program order.
    task automatic run_model();
        rv32i_types::rv32i_word pc, ins, a, b, res, next, imm_i, imm_s, addr;
        logic wr;
        int steps;
        for (int i = 0; i < 32; i++) begin
            mregs[i] = '0;
        end
        for (int i = 0; i < 1024; i++) begin
            mdmem[i] = data_pattern(i);
        end
        exp_addr.delete();
        exp_data.delete();
        pc = '0;
        steps = 0;
        while (imem[pc[9:2]] != LOOP_INSTR && steps < 1000) begin
            ins = imem[pc[9:2]];
            a = mregs[ins[19:15]];
            b = mregs[ins[24:20]];
            imm_i = {{20{ins[31]}}, ins[31:20]};
            imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
            next = pc + 4;
            wr = 1'b1;
            res = '0;
            case (ins[6:0])
                7'b0110011: res = alu_result(ins[14:12], ins[30], a, b);
                7'b0010011: res = alu_result(ins[14:12], ins[30] && ins[14:12] == 3'd5, a, imm_i);
                7'b0110111: res = {ins[31:12], 12'h000};
                7'b0010111: res = pc + {ins[31:12], 12'h000};
                7'b1101111: begin
                    res = pc + 4;
                    next = pc + {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
                end
                7'b1100011: begin
                    wr = 1'b0;
                    if (branch_taken(ins[14:12], a, b)) begin
                        next = pc + {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
                    end
                end
                7'b0000011: res = mdmem[(a + imm_i) >> 2 & 32'h3ff];
                default: begin
                    wr = 1'b0;
                    addr = a + imm_s;
                    exp_addr.push_back(addr);
                    exp_data.push_back(b);
                    mdmem[addr[11:2]] = b;
                end
            endcase
            if (wr && ins[11:7] != 5'd0) begin
                mregs[ins[11:7]] = res;
            end
            pc = next;
            steps++;
        end
    endtask

    task automatic serve_fetch();
        if (read_a && !busy_a) begin
            busy_a = 1'b1;
            wait_a = $urandom % 4;
        end
        resp_a = 1'b0;
        if (busy_a) begin
            if (wait_a == 0) begin
                // The instruction port only ever reads.
                check_flag("write_a", write_a, 1'b0);
                check_word("wmask_a", {28'b0, wmask_a}, 32'h0);
                check_word("wdata_a", wdata_a, 32'h0);
                resp_a = 1'b1;
                rdata_a = imem[address_a[9:2]];
                busy_a = 1'b0;
                if (address_a == LOOP_ADDR && exp_addr.size() == 0) begin
                    run_done = 1'b1;
                end
            end else begin
                wait_a--;
            end
        end
    endtask

    task automatic serve_data();
        if ((read_b || write_b) && !busy_b) begin
            busy_b = 1'b1;
            wait_b = $urandom % 4;
        end
        resp_b = 1'b0;
        if (busy_b) begin
            if (wait_b == 0) begin
                resp_b = 1'b1;
                busy_b = 1'b0;
                if (write_b) begin
                    check_word("wmask_b", {28'b0, wmask_b}, 32'hf);
                    if (exp_addr.size() == 0) begin
                        $display("Store to %h at %0t that the program never makes", address_b,
                                 $time);
                        $display("Test failed");
                        $fatal(1);
                    end
                    check_word("address_b", address_b, exp_addr.pop_front());
                    check_word("wdata_b", wdata_b, exp_data.pop_front());
                    dmem[address_b[11:2]] = wdata_b;
                end else begin
                    rdata_b = dmem[address_b[11:2]];
                end
            end else begin
                wait_b--;
            end
        end
    endtask

    always @(negedge clk) begin
        if (!arst_n) begin
            busy_a = 1'b0;
            busy_b = 1'b0;
            resp_a = 1'b0;
            resp_b = 1'b0;
        end else begin
            serve_fetch();
            serve_data();
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > CYCLE_LIMIT) begin
            $display("Timeout after %0d cycles without reaching the final loop", cycles);
            $display("Test failed");
            $fatal(1);
        end
    end

    initial begin
        resp_a = 1'b0;
        rdata_a = '0;
        resp_b = 1'b0;
        rdata_b = '0;
        prog_rst_n = 1'b0;
        run_done = 1'b0;
        busy_a = 1'b0;
        busy_b = 1'b0;
        cycles = 0;
        void'($urandom(65));
        for (int i = 0; i < 256; i++) begin
            imem[i] = NOP_INSTR;
        end
        wait (clk_rst_n);
        for (int p = 0; p < NUM_PROGS; p++) begin
            @(negedge clk);
            prog_rst_n <= 1'b0;
            gen_program();
            for (int i = 0; i < 1024; i++) begin
                dmem[i] = data_pattern(i);
            end
            run_model();
            run_done = 1'b0;
            repeat (2) @(negedge clk);
            prog_rst_n <= 1'b1;
            @(negedge clk);
            check_flag("read_b", read_b, 1'b0);
            check_flag("write_b", write_b, 1'b0);
            check_flag("write_a", write_a, 1'b0);
            check_flag("read_a", read_a, 1'b1);
            check_word("address_a", address_a, 32'h0000_0000);
            wait (run_done);
        end
        $display("Test passed");
        $finish;
    end

endmodule

/* pipe_control.sv */
`timescale 1ns/1ps

module pipe_control (
    input  logic                  read_a,
    input  logic                  resp_a,
    input  logic                  mem_busy,
    input  logic                  resp_b,
    input  logic                  ex_is_load,
    input  rv32i_types::rv32i_reg ex_rd,
    input  rv32i_types::rv32i_reg id_rs1,
    input  rv32i_types::rv32i_reg id_rs2,
    input  logic                  redirect,
    output logic                  load,
    output logic                  load_use_stall,
    output logic                  flush
);
    logic fetch_wait;
    logic data_wait;
    logic hazard;

    // Either port still waiting freezes every stage.
    assign fetch_wait = read_a & ~resp_a;
    assign data_wait = mem_busy & ~resp_b;
    assign load = ~(fetch_wait | data_wait);

    assign hazard = ex_is_load & ((ex_rd == id_rs1) | (ex_rd == id_rs2));

    // A taken branch squashes the waiting consumer anyway.
    assign flush = load & redirect;
    assign load_use_stall = load & hazard & ~redirect;

endmodule

/* pipe_types.sv */
package pipe_types;

    typedef struct packed {
        rv32i_types::rv32i_word pc;
        rv32i_types::rv32i_word instr;
        logic                   valid;
    } if_id_t;

    typedef struct packed {
        rv32i_types::rv32i_word         pc;
        rv32i_types::rv32i_word         rs1_out;
        rv32i_types::rv32i_word         rs2_out;
        rv32i_types::rv32i_control_word ctrl;
        logic                           valid;
    } id_ex_t;

    typedef struct packed {
        rv32i_types::rv32i_word         pc;
        rv32i_types::rv32i_word         alu_out;
        logic                           cmp_out;
        rv32i_types::rv32i_word         rs2_out;
        rv32i_types::rv32i_control_word ctrl;
        logic                           valid;
    } ex_mem_t;

    typedef struct packed {
        rv32i_types::rv32i_word         pc;
        rv32i_types::rv32i_word         alu_out;
        logic                           cmp_out;
        rv32i_types::rv32i_word         rs2_out;
        rv32i_types::rv32i_word         rdata;
        rv32i_types::rv32i_control_word ctrl;
        logic                           valid;
    } mem_wb_t;

    typedef enum logic [1:0] {
        fwd_none = 2'b00,
        fwd_mem  = 2'b01,
        fwd_wb   = 2'b10
    } fwd_sel;

    // Value an instruction writes to its destination register.
    function automatic rv32i_types::rv32i_word wb_value(input mem_wb_t r);
        case (r.ctrl.regfilemux)
            rv32i_types::rf_cmp:  return {31'b0, r.cmp_out};
            rv32i_types::rf_load: return r.rdata;
            rv32i_types::rf_pc4:  return r.pc + 32'd4;
            default:              return r.alu_out;
        endcase
    endfunction

endpackage

/* rv32i_types.sv */
package rv32i_types;

    typedef logic [31:0] rv32i_word;
    typedef logic [4:0] rv32i_reg;

    typedef enum logic [6:0] {
        op_lui   = 7'b0110111,
        op_auipc = 7'b0010111,
        op_jal   = 7'b1101111,
        op_jalr  = 7'b1100111,
        op_br    = 7'b1100011,
        op_load  = 7'b0000011,
        op_store = 7'b0100011,
        op_imm   = 7'b0010011,
        op_reg   = 7'b0110011
    } rv32i_opcode;

    // Encoded as {instr[30], funct3} so the decoder can cast directly.
    typedef enum logic [3:0] {
        alu_add  = 4'b0000,
        alu_sll  = 4'b0001,
        alu_slt  = 4'b0010,
        alu_sltu = 4'b0011,
        alu_xor  = 4'b0100,
        alu_srl  = 4'b0101,
        alu_or   = 4'b0110,
        alu_and  = 4'b0111,
        alu_sub  = 4'b1000,
        alu_sra  = 4'b1101
    } alu_ops;

    typedef enum logic [2:0] {
        beq  = 3'b000,
        bne  = 3'b001,
        blt  = 3'b100,
        bge  = 3'b101,
        bltu = 3'b110,
        bgeu = 3'b111
    } branch_funct3;

    typedef enum logic {
        mux1_rs1 = 1'b0,
        mux1_pc  = 1'b1
    } alumux1_sel;

    typedef enum logic {
        mux2_rs2 = 1'b0,
        mux2_imm = 1'b1
    } alumux2_sel;

    typedef enum logic [1:0] {
        rf_alu  = 2'b00,
        rf_cmp  = 2'b01,
        rf_load = 2'b10,
        rf_pc4  = 2'b11
    } regfilemux_sel;

    typedef struct packed {
        rv32i_opcode   opcode;
        rv32i_reg      rs1;
        rv32i_reg      rs2;
        rv32i_reg      rd;
        logic          load_regfile;
        logic          mem_read;
        logic          mem_write;
        alu_ops        aluop;
        branch_funct3  cmpop;
        alumux1_sel    alumux1;
        alumux2_sel    alumux2;
        regfilemux_sel regfilemux;
        rv32i_word     imm;
        logic          is_branch;
        logic          is_jal;
        logic          is_jalr;
    } rv32i_control_word;

endpackage

/* sources.f */
rv32i_types.sv
pipe_types.sv
control_memory.sv
id_stage.sv
ex_stage.sv
pipe_control.sv
mp3_cpu.sv
tb_clock.sv
mp3_cpu_asserts.sv
mp3_cpu_tb.sv

/* tb_clock.sv */
`timescale 1ns/1ps

module tb_clock #(
    parameter int PERIOD = 10,
    parameter int RESET_CYCLES = 2
) (
    output logic clk,
    output logic arst_n
);
    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // Reset is released on a falling edge, away from the active edge.
    initial begin
        arst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
    end

endmodule
